// ==== design/axi_lite_arbiter.sv ====
`default_nettype none

module axi_lite_arbiter (
    input  wire                       clk,
    input  wire                       reset,

    // fetch master, read only
    input  wire axi_mem_pkg::ar_req_t ifu_ar,
    input  wire                       ifu_ar_valid,
    output logic                      ifu_ar_ready,
    output axi_mem_pkg::r_rsp_t       ifu_r,
    output logic                      ifu_r_valid,
    input  wire                       ifu_r_ready,

    // load/store master
    input  wire axi_mem_pkg::ar_req_t lsu_ar,
    input  wire                       lsu_ar_valid,
    output logic                      lsu_ar_ready,
    output axi_mem_pkg::r_rsp_t       lsu_r,
    output logic                      lsu_r_valid,
    input  wire                       lsu_r_ready,
    input  wire axi_mem_pkg::aw_req_t lsu_aw,
    input  wire                       lsu_aw_valid,
    output logic                      lsu_aw_ready,
    input  wire axi_mem_pkg::w_req_t  lsu_w,
    input  wire                       lsu_w_valid,
    output logic                      lsu_w_ready,
    output axi_mem_pkg::b_rsp_t       lsu_b,
    output logic                      lsu_b_valid,
    input  wire                       lsu_b_ready,

    // towards the sram
    output axi_mem_pkg::ar_req_t      mem_ar,
    output logic                      mem_ar_valid,
    input  wire                       mem_ar_ready,
    input  wire axi_mem_pkg::r_rsp_t  mem_r,
    input  wire                       mem_r_valid,
    output logic                      mem_r_ready,
    output axi_mem_pkg::aw_req_t      mem_aw,
    output logic                      mem_aw_valid,
    input  wire                       mem_aw_ready,
    output axi_mem_pkg::w_req_t       mem_w,
    output logic                      mem_w_valid,
    input  wire                       mem_w_ready,
    input  wire axi_mem_pkg::b_rsp_t  mem_b,
    input  wire                       mem_b_valid,
    output logic                      mem_b_ready
);

    import axi_mem_pkg::*;

    grant_e grant;
    logic   last_lsu;
    logic   sel_lsu;
    logic   ar_idle;
    logic   ar_take;

    assign ar_idle = (grant == GRANT_NONE);

    // on a tie the master that lost last time goes first
    always_comb begin
        if (ifu_ar_valid && lsu_ar_valid) begin
            sel_lsu = !last_lsu;
        end else begin
            sel_lsu = lsu_ar_valid;
        end
    end

    assign mem_ar       = sel_lsu ? lsu_ar : ifu_ar;
    assign mem_ar_valid = ar_idle && (ifu_ar_valid || lsu_ar_valid);
    assign ifu_ar_ready = ar_idle && !sel_lsu && mem_ar_ready;
    assign lsu_ar_ready = ar_idle && sel_lsu && mem_ar_ready;
    assign ar_take      = mem_ar_valid && mem_ar_ready;

    // response payload is shared, valid only goes to the owner
    assign ifu_r       = mem_r;
    assign lsu_r       = mem_r;
    assign ifu_r_valid = mem_r_valid && (grant == GRANT_IFU);
    assign lsu_r_valid = mem_r_valid && (grant == GRANT_LSU);

    always_comb begin
        case (grant)
            GRANT_IFU: mem_r_ready = ifu_r_ready;
            GRANT_LSU: mem_r_ready = lsu_r_ready;
            default:   mem_r_ready = 1'b0;
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            grant    <= GRANT_NONE;
            last_lsu <= 1'b0;
        end else begin
            case (grant)
                GRANT_NONE: begin
                    if (ar_take) begin
                        grant    <= sel_lsu ? GRANT_LSU : GRANT_IFU;
                        last_lsu <= sel_lsu;
                    end
                end
                default: begin
                    if (mem_r_valid && mem_r_ready) begin
                        grant <= GRANT_NONE;
                    end
                end
            endcase
        end
    end

    // only lsu writes
    assign mem_aw       = lsu_aw;
    assign mem_aw_valid = lsu_aw_valid;
    assign lsu_aw_ready = mem_aw_ready;
    assign mem_w        = lsu_w;
    assign mem_w_valid  = lsu_w_valid;
    assign lsu_w_ready  = mem_w_ready;
    assign lsu_b        = mem_b;
    assign lsu_b_valid  = mem_b_valid;
    assign mem_b_ready  = lsu_b_ready;

endmodule

`default_nettype wire

// ==== design/axi_lite_sram.sv ====
`default_nettype none

`include "axi_mem_cfg.svh"

module axi_lite_sram (
    input  wire                    clk,
    input  wire                    reset,

    input  wire axi_mem_pkg::ar_req_t ar,
    input  wire                    ar_valid,
    output logic                   ar_ready,

    output axi_mem_pkg::r_rsp_t    r,
    output logic                   r_valid,
    input  wire                    r_ready,

    input  wire axi_mem_pkg::aw_req_t aw,
    input  wire                    aw_valid,
    output logic                   aw_ready,

    input  wire axi_mem_pkg::w_req_t w,
    input  wire                    w_valid,
    output logic                   w_ready,

    output axi_mem_pkg::b_rsp_t    b,
    output logic                   b_valid,
    input  wire                    b_ready
);

    import axi_mem_pkg::*;

    localparam int ADDR_LSB = 2;
    localparam int IDX_W    = $clog2(`SRAM_DEPTH_WORDS);
    localparam int STRB_W   = `AXI_DATA_W / 8;
    localparam int CNT_W    = $clog2(`SRAM_LATENCY + 2);

    logic [`AXI_DATA_W-1:0] mem [`SRAM_DEPTH_WORDS];

    rd_state_e        rd_state;
    logic [CNT_W-1:0] rd_cnt;
    r_rsp_t           rd_rsp_q;
    logic             rd_accept;
    logic             rd_in_range;
    logic [IDX_W-1:0] rd_idx;

    wr_state_e        wr_state;
    logic [CNT_W-1:0] wr_cnt;
    b_rsp_t           wr_rsp_q;
    logic             wr_accept;
    logic             wr_in_range;
    logic [IDX_W-1:0] wr_idx;

    // everything above the word index must be zero
    function automatic logic addr_in_range(input logic [`AXI_ADDR_W-1:0] addr);
        return addr[`AXI_ADDR_W-1:ADDR_LSB+IDX_W] == '0;
    endfunction

    // read engine
    assign ar_ready    = (rd_state == RD_IDLE);
    assign rd_accept   = ar_valid && ar_ready;
    assign rd_in_range = addr_in_range(ar.addr);
    assign rd_idx      = ar.addr[ADDR_LSB+IDX_W-1:ADDR_LSB];
    assign r_valid     = (rd_state == RD_RESP);
    assign r           = rd_rsp_q;

    always_ff @(posedge clk) begin
        if (reset) begin
            rd_state <= RD_IDLE;
            rd_cnt   <= '0;
        end else begin
            case (rd_state)
                RD_IDLE: begin
                    if (rd_accept) begin
                        rd_state <= RD_WAIT;
                        rd_cnt   <= '0;
                    end
                end
                RD_WAIT: begin
                    if (rd_cnt == CNT_W'(`SRAM_LATENCY)) begin
                        rd_state <= RD_RESP;
                    end else begin
                        rd_cnt <= rd_cnt + 1'b1;
                    end
                end
                RD_RESP: begin
                    if (r_ready) begin
                        rd_state <= RD_IDLE;
                    end
                end
                default: rd_state <= RD_IDLE;
            endcase
        end
    end

    // word is sampled at accept, held until the r transfer
    always_ff @(posedge clk) begin
        if (rd_accept) begin
            rd_rsp_q.data <= rd_in_range ? mem[rd_idx] : '0;
            rd_rsp_q.resp <= rd_in_range ? RESP_OKAY : RESP_SLVERR;
        end
    end

    // write engine, address and data taken in the same cycle
    assign wr_accept   = (wr_state == WR_IDLE) && aw_valid && w_valid;
    assign aw_ready    = wr_accept;
    assign w_ready     = wr_accept;
    assign wr_in_range = addr_in_range(aw.addr);
    assign wr_idx      = aw.addr[ADDR_LSB+IDX_W-1:ADDR_LSB];
    assign b_valid     = (wr_state == WR_RESP);
    assign b           = wr_rsp_q;

    always_ff @(posedge clk) begin
        if (reset) begin
            wr_state <= WR_IDLE;
            wr_cnt   <= '0;
        end else begin
            case (wr_state)
                WR_IDLE: begin
                    if (wr_accept) begin
                        wr_state <= WR_WAIT;
                        wr_cnt   <= '0;
                    end
                end
                WR_WAIT: begin
                    if (wr_cnt == CNT_W'(`SRAM_LATENCY)) begin
                        wr_state <= WR_RESP;
                    end else begin
                        wr_cnt <= wr_cnt + 1'b1;
                    end
                end
                WR_RESP: begin
                    if (b_ready) begin
                        wr_state <= WR_IDLE;
                    end
                end
                default: wr_state <= WR_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (wr_accept) begin
            wr_rsp_q.resp <= wr_in_range ? RESP_OKAY : RESP_SLVERR;
        end
    end

    // byte lane merge
    always_ff @(posedge clk) begin
        if (wr_accept && wr_in_range) begin
            for (int i = 0; i < STRB_W; i++) begin
                if (w.strb[i]) begin
                    mem[wr_idx][8*i +: 8] <= w.data[8*i +: 8];
                end
            end
        end
    end

endmodule

`default_nettype wire

// ==== design/axi_mem_cfg.svh ====
`ifndef AXI_MEM_CFG_SVH
`define AXI_MEM_CFG_SVH

// bus widths
`define AXI_ADDR_W 32
`define AXI_DATA_W 32

// word count, bytes 4096 and up are out of range
`define SRAM_DEPTH_WORDS 1024

// wait cycles between accept and response
`define SRAM_LATENCY 2

`endif

// ==== design/axi_mem_pkg.sv ====
`default_nettype none

`include "axi_mem_cfg.svh"

package axi_mem_pkg;

    typedef enum logic [1:0] {
        RESP_OKAY   = 2'b00,
        RESP_SLVERR = 2'b10
    } resp_e;

    typedef struct packed {
        logic [`AXI_ADDR_W-1:0] addr;
    } ar_req_t;

    typedef struct packed {
        logic [`AXI_DATA_W-1:0] data;
        resp_e                  resp;
    } r_rsp_t;

    typedef struct packed {
        logic [`AXI_ADDR_W-1:0] addr;
    } aw_req_t;

    typedef struct packed {
        logic [`AXI_DATA_W-1:0]   data;
        logic [`AXI_DATA_W/8-1:0] strb;
    } w_req_t;

    typedef struct packed {
        resp_e resp;
    } b_rsp_t;

    // sram engines
    typedef enum logic [1:0] {
        RD_IDLE,
        RD_WAIT,
        RD_RESP
    } rd_state_e;

    typedef enum logic [1:0] {
        WR_IDLE,
        WR_WAIT,
        WR_RESP
    } wr_state_e;

    // read channel owner in the arbiter
    typedef enum logic [1:0] {
        GRANT_NONE,
        GRANT_IFU,
        GRANT_LSU
    } grant_e;

endpackage

`default_nettype wire

// ==== design/mem_subsystem.sv ====
`default_nettype none

module mem_subsystem (
    input  wire                       clk,
    input  wire                       reset,

    input  wire axi_mem_pkg::ar_req_t ifu_ar,
    input  wire                       ifu_ar_valid,
    output logic                      ifu_ar_ready,
    output axi_mem_pkg::r_rsp_t       ifu_r,
    output logic                      ifu_r_valid,
    input  wire                       ifu_r_ready,

    input  wire axi_mem_pkg::ar_req_t lsu_ar,
    input  wire                       lsu_ar_valid,
    output logic                      lsu_ar_ready,
    output axi_mem_pkg::r_rsp_t       lsu_r,
    output logic                      lsu_r_valid,
    input  wire                       lsu_r_ready,
    input  wire axi_mem_pkg::aw_req_t lsu_aw,
    input  wire                       lsu_aw_valid,
    output logic                      lsu_aw_ready,
    input  wire axi_mem_pkg::w_req_t  lsu_w,
    input  wire                       lsu_w_valid,
    output logic                      lsu_w_ready,
    output axi_mem_pkg::b_rsp_t       lsu_b,
    output logic                      lsu_b_valid,
    input  wire                       lsu_b_ready
);

    import axi_mem_pkg::*;

    // single slave port between arbiter and sram
    ar_req_t mem_ar;
    logic    mem_ar_valid;
    logic    mem_ar_ready;
    r_rsp_t  mem_r;
    logic    mem_r_valid;
    logic    mem_r_ready;
    aw_req_t mem_aw;
    logic    mem_aw_valid;
    logic    mem_aw_ready;
    w_req_t  mem_w;
    logic    mem_w_valid;
    logic    mem_w_ready;
    b_rsp_t  mem_b;
    logic    mem_b_valid;
    logic    mem_b_ready;

    axi_lite_arbiter i_arbiter (
        .clk          (clk),
        .reset        (reset),
        .ifu_ar       (ifu_ar),
        .ifu_ar_valid (ifu_ar_valid),
        .ifu_ar_ready (ifu_ar_ready),
        .ifu_r        (ifu_r),
        .ifu_r_valid  (ifu_r_valid),
        .ifu_r_ready  (ifu_r_ready),
        .lsu_ar       (lsu_ar),
        .lsu_ar_valid (lsu_ar_valid),
        .lsu_ar_ready (lsu_ar_ready),
        .lsu_r        (lsu_r),
        .lsu_r_valid  (lsu_r_valid),
        .lsu_r_ready  (lsu_r_ready),
        .lsu_aw       (lsu_aw),
        .lsu_aw_valid (lsu_aw_valid),
        .lsu_aw_ready (lsu_aw_ready),
        .lsu_w        (lsu_w),
        .lsu_w_valid  (lsu_w_valid),
        .lsu_w_ready  (lsu_w_ready),
        .lsu_b        (lsu_b),
        .lsu_b_valid  (lsu_b_valid),
        .lsu_b_ready  (lsu_b_ready),
        .mem_ar       (mem_ar),
        .mem_ar_valid (mem_ar_valid),
        .mem_ar_ready (mem_ar_ready),
        .mem_r        (mem_r),
        .mem_r_valid  (mem_r_valid),
        .mem_r_ready  (mem_r_ready),
        .mem_aw       (mem_aw),
        .mem_aw_valid (mem_aw_valid),
        .mem_aw_ready (mem_aw_ready),
        .mem_w        (mem_w),
        .mem_w_valid  (mem_w_valid),
        .mem_w_ready  (mem_w_ready),
        .mem_b        (mem_b),
        .mem_b_valid  (mem_b_valid),
        .mem_b_ready  (mem_b_ready)
    );

    axi_lite_sram i_sram (
        .clk      (clk),
        .reset    (reset),
        .ar       (mem_ar),
        .ar_valid (mem_ar_valid),
        .ar_ready (mem_ar_ready),
        .r        (mem_r),
        .r_valid  (mem_r_valid),
        .r_ready  (mem_r_ready),
        .aw       (mem_aw),
        .aw_valid (mem_aw_valid),
        .aw_ready (mem_aw_ready),
        .w        (mem_w),
        .w_valid  (mem_w_valid),
        .w_ready  (mem_w_ready),
        .b        (mem_b),
        .b_valid  (mem_b_valid),
        .b_ready  (mem_b_ready)
    );

endmodule

`default_nettype wire

// ==== files.f ====
+incdir+design
design/axi_mem_pkg.sv
design/axi_lite_sram.sv
design/axi_lite_arbiter.sv
design/mem_subsystem.sv
test/mem_subsystem_asserts.sv
test/tb_mem_subsystem.sv

// ==== run.sh ====
#!/bin/sh
# build the testbench with Verilator and run it

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -j 0 \
    --top-module tb_mem_subsystem \
    -Mdir obj_dir \
    -f files.f
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

out=$(./obj_dir/Vtb_mem_subsystem)
status=$?
printf '%s\n' "$out"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if printf '%s\n' "$out" | grep -qx "PASS: all tests"; then
    exit 0
fi
echo "pass message not found"
exit 1

// ==== test/mem_subsystem_asserts.sv ====
`default_nettype none

module mem_subsystem_asserts (
    input wire                      clk,
    input wire                      reset,
    input wire axi_mem_pkg::r_rsp_t ifu_r,
    input wire                      ifu_r_valid,
    input wire                      ifu_r_ready,
    input wire axi_mem_pkg::r_rsp_t lsu_r,
    input wire                      lsu_r_valid,
    input wire                      lsu_r_ready,
    input wire axi_mem_pkg::b_rsp_t lsu_b,
    input wire                      lsu_b_valid,
    input wire                      lsu_b_ready
);

    import axi_mem_pkg::*;

    // nothing pending once reset is released
    a_reset_idle: assert property (@(posedge clk)
        reset |=> !ifu_r_valid && !lsu_r_valid && !lsu_b_valid)
        else $error("response valid high in the cycle after reset");

    a_ifu_r_hold: assert property (@(posedge clk) disable iff (reset)
        ifu_r_valid && !ifu_r_ready |=> ifu_r_valid && $stable(ifu_r))
        else $error("ifu_r changed or dropped while stalled");

    a_lsu_r_hold: assert property (@(posedge clk) disable iff (reset)
        lsu_r_valid && !lsu_r_ready |=> lsu_r_valid && $stable(lsu_r))
        else $error("lsu_r changed or dropped while stalled");

    a_lsu_b_hold: assert property (@(posedge clk) disable iff (reset)
        lsu_b_valid && !lsu_b_ready |=> lsu_b_valid && $stable(lsu_b))
        else $error("lsu_b changed or dropped while stalled");

    // one read owner at a time
    a_r_onehot: assert property (@(posedge clk) disable iff (reset)
        !(ifu_r_valid && lsu_r_valid))
        else $error("ifu_r_valid and lsu_r_valid high together");

endmodule

`default_nettype wire

// ==== test/tb_mem_subsystem.sv ====
`default_nettype none

`include "axi_mem_cfg.svh"

module tb_mem_subsystem;

    import axi_mem_pkg::*;

    localparam int HALF_PERIOD = 10;
    localparam int SETTLE      = 5;
    localparam int TIMEOUT     = 100;
    localparam int RD_LAT      = `SRAM_LATENCY + 1;
    localparam int MEM_BYTES   = `SRAM_DEPTH_WORDS * 4;
    localparam int IDX_W       = $clog2(`SRAM_DEPTH_WORDS);
    localparam int SEED        = 67;
    localparam int BP_OPS      = 24;

    // expected read response and the cycle of its ar transfer
    typedef struct packed {
        r_rsp_t      rsp;
        logic [31:0] ar_cycle;
    } rd_exp_t;

    logic    clk = 1'b0;
    logic    reset;
    ar_req_t ifu_ar;
    logic    ifu_ar_valid;
    logic    ifu_ar_ready;
    r_rsp_t  ifu_r;
    logic    ifu_r_valid;
    logic    ifu_r_ready;
    ar_req_t lsu_ar;
    logic    lsu_ar_valid;
    logic    lsu_ar_ready;
    r_rsp_t  lsu_r;
    logic    lsu_r_valid;
    logic    lsu_r_ready;
    aw_req_t lsu_aw;
    logic    lsu_aw_valid;
    logic    lsu_aw_ready;
    w_req_t  lsu_w;
    logic    lsu_w_valid;
    logic    lsu_w_ready;
    b_rsp_t  lsu_b;
    logic    lsu_b_valid;
    logic    lsu_b_ready;

    logic [`AXI_DATA_W-1:0] shadow [`SRAM_DEPTH_WORDS];
    logic [31:0] written [$];
    rd_exp_t     ifu_exp_q [$];
    rd_exp_t     lsu_exp_q [$];
    b_rsp_t      b_exp_q [$];
    logic [31:0] bp_ifu_addr [BP_OPS];
    logic [31:0] bp_lsu_addr [BP_OPS];
    logic [31:0] bp_lsu_data [BP_OPS];
    logic [31:0] cycle;
    logic [31:0] ifu_start;
    logic [31:0] lsu_start;
    logic [31:0] ifu_ar_at;
    logic [31:0] lsu_ar_at;
    logic        last_rd_lsu;
    logic        ifu_seen;
    logic        lsu_seen;
    logic        stall_en;
    logic        timed_out;
    integer      seed;
    integer      ifu_seed;
    integer      lsu_seed;
    integer      b_seed;
    int          errors;
    int          checks;
    int          err_mark;
    int          ifu_req_cnt;
    int          ifu_rsp_cnt;
    int          lsu_req_cnt;
    int          lsu_rsp_cnt;
    int          b_req_cnt;
    int          b_rsp_cnt;

    mem_subsystem i_dut (
        .clk          (clk),
        .reset        (reset),
        .ifu_ar       (ifu_ar),
        .ifu_ar_valid (ifu_ar_valid),
        .ifu_ar_ready (ifu_ar_ready),
        .ifu_r        (ifu_r),
        .ifu_r_valid  (ifu_r_valid),
        .ifu_r_ready  (ifu_r_ready),
        .lsu_ar       (lsu_ar),
        .lsu_ar_valid (lsu_ar_valid),
        .lsu_ar_ready (lsu_ar_ready),
        .lsu_r        (lsu_r),
        .lsu_r_valid  (lsu_r_valid),
        .lsu_r_ready  (lsu_r_ready),
        .lsu_aw       (lsu_aw),
        .lsu_aw_valid (lsu_aw_valid),
        .lsu_aw_ready (lsu_aw_ready),
        .lsu_w        (lsu_w),
        .lsu_w_valid  (lsu_w_valid),
        .lsu_w_ready  (lsu_w_ready),
        .lsu_b        (lsu_b),
        .lsu_b_valid  (lsu_b_valid),
        .lsu_b_ready  (lsu_b_ready)
    );

    bind mem_subsystem mem_subsystem_asserts i_asserts (
        .clk         (clk),
        .reset       (reset),
        .ifu_r       (ifu_r),
        .ifu_r_valid (ifu_r_valid),
        .ifu_r_ready (ifu_r_ready),
        .lsu_r       (lsu_r),
        .lsu_r_valid (lsu_r_valid),
        .lsu_r_ready (lsu_r_ready),
        .lsu_b       (lsu_b),
        .lsu_b_valid (lsu_b_valid),
        .lsu_b_ready (lsu_b_ready)
    );

    always #HALF_PERIOD clk = ~clk;

    always @(posedge clk) begin
        if (reset) begin
            cycle <= '0;
        end else begin
            cycle <= cycle + 1;
        end
    end

    // reference model of the memory
    function automatic r_rsp_t expected_read(input logic [31:0] addr);
        r_rsp_t rsp;
        if (addr >= MEM_BYTES) begin
            rsp.data = '0;
            rsp.resp = RESP_SLVERR;
        end else begin
            rsp.data = shadow[addr[IDX_W+1:2]];
            rsp.resp = RESP_OKAY;
        end
        return rsp;
    endfunction

    function automatic b_rsp_t expected_bresp(input logic [31:0] addr);
        b_rsp_t rsp;
        rsp.resp = (addr >= MEM_BYTES) ? RESP_SLVERR : RESP_OKAY;
        return rsp;
    endfunction

    function automatic void shadow_write(input logic [31:0] addr, input w_req_t w);
        logic [31:0] mask;
        mask = '0;
        for (int i = 0; i < 4; i++) begin
            mask[8*i +: 8] = {8{w.strb[i]}};
        end
        if (addr < MEM_BYTES) begin
            shadow[addr[IDX_W+1:2]] = (shadow[addr[IDX_W+1:2]] & ~mask) | (w.data & mask);
        end
    endfunction

    task automatic report_timeout(input string what);
        $display("Timeout: %s did not complete within %0d cycles", what, TIMEOUT);
        errors++;
        timed_out = 1'b1;
    endtask

    task automatic report_extra(input string chan);
        $display("Unexpected response on %s with nothing outstanding", chan);
        errors++;
    endtask

    task automatic report_test(input int num, input string name);
        $display("test %0d %s: %0d errors", num, name, errors - err_mark);
        err_mark = errors;
    endtask

    task automatic check_read(input string chan, input r_rsp_t got, input logic [31:0] start,
                              input rd_exp_t want);
        checks += 3;
        assert (got.data === want.rsp.data) else begin
            $display("Error: %s.data got %h expected %h", chan, got.data, want.rsp.data);
            errors++;
        end
        assert (got.resp === want.rsp.resp) else begin
            $display("Error: %s.resp got %h expected %h", chan, got.resp, want.rsp.resp);
            errors++;
        end
        assert (start - want.ar_cycle == RD_LAT) else begin
            $display("Error: %s_valid latency got %h expected %h", chan,
                     start - want.ar_cycle, RD_LAT);
            errors++;
        end
    endtask

    // lsu write that waits for its b response
    task automatic write_word(input logic [31:0] addr, input logic [31:0] data,
                              input logic [3:0] strb);
        int     n;
        int     target;
        w_req_t w;
        if (timed_out) return;
        @(negedge clk);
        target       = b_rsp_cnt + 1;
        w.data       = data;
        w.strb       = strb;
        lsu_aw.addr  = addr;
        lsu_w        = w;
        lsu_aw_valid = 1'b1;
        lsu_w_valid  = 1'b1;
        n = 0;
        #SETTLE;
        while (!(lsu_aw_ready && lsu_w_ready) && n < TIMEOUT) begin
            @(negedge clk);
            #SETTLE;
            n++;
        end
        if (!(lsu_aw_ready && lsu_w_ready)) begin
            report_timeout("write address and data handshake");
            return;
        end
        @(posedge clk);
        b_req_cnt++;
        @(negedge clk);
        lsu_aw_valid = 1'b0;
        lsu_w_valid  = 1'b0;
        b_exp_q.push_back(expected_bresp(addr));
        shadow_write(addr, w);
        n = 0;
        while (b_rsp_cnt < target && n < TIMEOUT) begin
            @(negedge clk);
            n++;
        end
        if (b_rsp_cnt < target) begin
            report_timeout("write response");
        end
    endtask

    // read through one master and wait for its r response
    task automatic read_word(input logic use_lsu, input logic [31:0] addr);
        int      n;
        int      target;
        rd_exp_t want;
        if (timed_out) return;
        @(negedge clk);
        if (use_lsu) begin
            target       = lsu_rsp_cnt + 1;
            lsu_ar.addr  = addr;
            lsu_ar_valid = 1'b1;
        end else begin
            target       = ifu_rsp_cnt + 1;
            ifu_ar.addr  = addr;
            ifu_ar_valid = 1'b1;
        end
        n = 0;
        #SETTLE;
        while (!(use_lsu ? lsu_ar_ready : ifu_ar_ready) && n < TIMEOUT) begin
            @(negedge clk);
            #SETTLE;
            n++;
        end
        if (!(use_lsu ? lsu_ar_ready : ifu_ar_ready)) begin
            report_timeout("read address handshake");
            return;
        end
        @(posedge clk);
        if (use_lsu) begin
            lsu_req_cnt++;
        end else begin
            ifu_req_cnt++;
        end
        @(negedge clk);
        want.rsp      = expected_read(addr);
        want.ar_cycle = cycle;
        last_rd_lsu   = use_lsu;
        if (use_lsu) begin
            lsu_ar_valid = 1'b0;
            lsu_ar_at    = cycle;
            lsu_exp_q.push_back(want);
        end else begin
            ifu_ar_valid = 1'b0;
            ifu_ar_at    = cycle;
            ifu_exp_q.push_back(want);
        end
        n = 0;
        while ((use_lsu ? lsu_rsp_cnt : ifu_rsp_cnt) < target && n < TIMEOUT) begin
            @(negedge clk);
            n++;
        end
        if ((use_lsu ? lsu_rsp_cnt : ifu_rsp_cnt) < target) begin
            report_timeout("read response");
        end
    endtask

    // one process per response channel drives ready and compares
    initial begin : ifu_r_monitor
        ifu_r_ready = 1'b1;
        ifu_seen    = 1'b0;
        forever begin
            @(negedge clk);
            ifu_r_ready = stall_en ? 1'($random(ifu_seed)) : 1'b1;
            #SETTLE;
            if (ifu_r_valid && !ifu_seen) begin
                ifu_seen  = 1'b1;
                ifu_start = cycle;
            end
            if (ifu_r_valid && ifu_r_ready) begin
                ifu_seen = 1'b0;
                ifu_rsp_cnt++;
                if (ifu_exp_q.size() == 0) begin
                    report_extra("ifu_r");
                end else begin
                    check_read("ifu_r", ifu_r, ifu_start, ifu_exp_q.pop_front());
                end
            end
        end
    end

    initial begin : lsu_r_monitor
        lsu_r_ready = 1'b1;
        lsu_seen    = 1'b0;
        forever begin
            @(negedge clk);
            lsu_r_ready = stall_en ? 1'($random(lsu_seed)) : 1'b1;
            #SETTLE;
            if (lsu_r_valid && !lsu_seen) begin
                lsu_seen  = 1'b1;
                lsu_start = cycle;
            end
            if (lsu_r_valid && lsu_r_ready) begin
                lsu_seen = 1'b0;
                lsu_rsp_cnt++;
                if (lsu_exp_q.size() == 0) begin
                    report_extra("lsu_r");
                end else begin
                    check_read("lsu_r", lsu_r, lsu_start, lsu_exp_q.pop_front());
                end
            end
        end
    end

    initial begin : lsu_b_monitor
        b_rsp_t want;
        lsu_b_ready = 1'b1;
        forever begin
            @(negedge clk);
            lsu_b_ready = stall_en ? 1'($random(b_seed)) : 1'b1;
            #SETTLE;
            if (lsu_b_valid && lsu_b_ready) begin
                b_rsp_cnt++;
                if (b_exp_q.size() == 0) begin
                    report_extra("lsu_b");
                end else begin
                    want = b_exp_q.pop_front();
                    checks++;
                    assert (lsu_b.resp === want.resp) else begin
                        $display("Error: lsu_b.resp got %h expected %h", lsu_b.resp, want.resp);
                        errors++;
                    end
                end
            end
        end
    end

    initial begin : stimulus
        logic [31:0] addr;
        logic [31:0] lo;
        logic [3:0]  strb;
        logic        lsu_first;
        seed         = SEED;
        ifu_seed     = SEED;
        lsu_seed     = SEED;
        b_seed       = SEED;
        errors       = 0;
        checks       = 0;
        err_mark     = 0;
        ifu_req_cnt  = 0;
        ifu_rsp_cnt  = 0;
        lsu_req_cnt  = 0;
        lsu_rsp_cnt  = 0;
        b_req_cnt    = 0;
        b_rsp_cnt    = 0;
        ifu_ar_at    = '0;
        lsu_ar_at    = '0;
        last_rd_lsu  = 1'b0;
        stall_en     = 1'b0;
        timed_out    = 1'b0;
        reset        = 1'b1;
        ifu_ar       = '0;
        ifu_ar_valid = 1'b0;
        lsu_ar       = '0;
        lsu_ar_valid = 1'b0;
        lsu_aw       = '0;
        lsu_aw_valid = 1'b0;
        lsu_w        = '0;
        lsu_w_valid  = 1'b0;
        repeat (8) @(negedge clk);
        reset = 1'b0;

        // quiet bus before a first write and read
        repeat (10) begin
            @(negedge clk);
            checks++;
            assert (!ifu_r_valid && !lsu_r_valid && !lsu_b_valid) else begin
                $display("a response valid rose after reset with no request");
                errors++;
            end
        end
        write_word(32'h10, $random(seed), 4'hf);
        read_word(1'b0, 32'h10);
        report_test(1, "reset state");

        // lower half of memory is read back through both masters at once
        for (int i = 0; i < 64; i++) begin
            addr = $random(seed) & 32'h7fc;
            written.push_back(addr);
            write_word(addr, $random(seed), 4'hf);
            fork
                read_word(1'b0, addr);
                read_word(1'b1, addr);
            join
        end
        report_test(2, "write/read back");

        for (int i = 0; i < 32; i++) begin
            addr = written[$unsigned($random(seed)) % written.size()];
            strb = 4'($random(seed));
            write_word(addr, $random(seed), strb);
            read_word(1'b0, addr);
        end
        report_test(3, "byte strobes");

        for (int i = 0; i < 4; i++) begin
            lo   = written[i];
            addr = (i % 2 == 0) ? lo + MEM_BYTES : lo | 32'h8000_0000;
            write_word(addr, $random(seed), 4'hf);
            read_word(1'b1, addr);
            read_word(1'b0, lo);
        end
        report_test(4, "out of range");

        // a tie goes to the master not granted last
        for (int i = 0; i < 16; i++) begin
            lsu_first = !last_rd_lsu;
            fork
                read_word(1'b0, written[i]);
                read_word(1'b1, written[63 - i]);
            join
            checks++;
            assert ((lsu_ar_at < ifu_ar_at) == lsu_first) else begin
                $display("tie %0d granted %s first although %s was granted last", i,
                         lsu_first ? "ifu" : "lsu", lsu_first ? "ifu" : "lsu");
                errors++;
            end
        end
        report_test(5, "arbitration");

        // lsu stays in the upper half so ifu reads never race its writes
        for (int i = 0; i < BP_OPS; i++) begin
            bp_ifu_addr[i] = written[$unsigned($random(seed)) % written.size()];
            bp_lsu_addr[i] = ($random(seed) & 32'h7fc) | 32'h800;
            bp_lsu_data[i] = $random(seed);
        end
        stall_en = 1'b1;
        fork
            begin
                for (int i = 0; i < BP_OPS; i++) begin
                    read_word(1'b0, bp_ifu_addr[i]);
                end
            end
            begin
                for (int j = 0; j < BP_OPS; j++) begin
                    write_word(bp_lsu_addr[j], bp_lsu_data[j], 4'hf);
                    read_word(1'b1, bp_lsu_addr[j]);
                end
            end
        join
        stall_en = 1'b0;
        checks += 3;
        assert (ifu_rsp_cnt == ifu_req_cnt) else begin
            $display("Error: ifu response count got %h expected %h", ifu_rsp_cnt, ifu_req_cnt);
            errors++;
        end
        assert (lsu_rsp_cnt == lsu_req_cnt) else begin
            $display("Error: lsu response count got %h expected %h", lsu_rsp_cnt, lsu_req_cnt);
            errors++;
        end
        assert (b_rsp_cnt == b_req_cnt) else begin
            $display("Error: lsu_b response count got %h expected %h", b_rsp_cnt, b_req_cnt);
            errors++;
        end
        report_test(6, "back-pressure");

        $display("tests 6, checks %0d, errors %0d", checks, errors);
        if (errors == 0) begin
            $display("PASS: all tests");
        end else begin
            $display("FAIL: see errors above");
        end
        $finish;
    end

endmodule

`default_nettype wire
